/* verif/qdr_cfg_patterns.txt */
// op addr data expected byte_enables
// op 0 waits and checks pulse counts, 1 reads, 2 writes, 3 ends the list
0 00000000 00000000 00000000 0 // counters still 0 after reset
1 00001004 00000000 00000101 f // status with cal_fail and phy_rdy high
1 00001020 00000000 3c5a0f96 f
1 00001024 00000000 00000000 f
1 00001008 00000000 00000000 f // unmapped index
1 0000103c 00000000 00000000 f
1 00001040 00000000 00000000 f // first address above the window
1 00000ffc 00000000 00000000 f
2 00001010 0000f00f 00000000 f
0 00000000 00000000 00000000 0
1 00001010 00000000 0000f00f f
2 00001010 0000ff0c 00000000 f // bits 11..8 rise, bits 1..0 clear
2 00001014 000001ff 00000000 f
2 00001018 a5a5a5a5 00000000 f
2 0000101c 00000001 00000000 f
0 00000000 00000000 00000000 0
1 00001014 00000000 000001ff f
1 00001018 00000000 a5a5a5a5 f
1 0000101c 00000000 00000001 f
2 00001010 ffffffff 00000000 f // back to back under back-pressure
2 00001014 00000000 00000000 f
2 00001018 5a5a5a5a 00000000 f
2 0000101c 00000000 00000000 f
2 00001014 00000015 00000000 f
0 00000000 00000000 00000000 0
1 00001010 00000000 ffffffff f
1 00001014 00000000 00000015 f
2 00001024 00000001 00000000 f
1 00001024 00000000 00000001 f
2 00001024 00000000 00000000 f
2 00001000 00000001 00000000 f // reset with byte lane 3 enabled
2 00001000 00000001 00000000 e
2 00001000 00000000 00000000 f
3 00000000 00000000 00000000 0

/* list.f */
source/qdr_cfg_pkg.sv
source/qdr_reset_gen.sv
source/qdr_dly_xfer.sv
source/qdr_cfg_ctrl.sv
source/qdr_cfg_top.sv
verif/tb_clkgen.sv
verif/qdr_cfg_chk.sv
verif/qdr_cfg_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := qdr_cfg_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verif/qdr_cfg_tb.sv */
`timescale 1ns/1ps

module qdr_cfg_tb
  import qdr_cfg_pkg::*;
();

  localparam logic [31:0] BASE = 32'h0000_1000;
  localparam logic [31:0] HIGH = 32'h0000_1040;
  localparam int RESET_CYCLES  = 8;
  localparam int MAX_LINES     = 64;
  localparam int LINE_BUDGET   = 200;  // OPB cycles allowed per pattern line
  localparam int MISS_WAIT     = 10;
  localparam int SETTLE        = 20;   // dly_clk cycles for one handshake and its pulses

  logic          OPB_Clk;
  logic          dly_clk;
  logic          qdr_clk;
  logic          rst_n;
  logic [31:0]   opb_abus;
  logic [3:0]    opb_be;
  logic [31:0]   opb_dbus;
  logic          opb_rnw;
  logic          opb_select;
  logic          sl_xfer_ack;
  logic [31:0]   sl_dbus;
  logic          cal_fail;
  logic          phy_rdy;
  logic [31:0]   dly_cntrs_lo;
  dly_in_mask_t  dly_en_i;
  dly_out_mask_t dly_en_o;
  logic          dly_inc_dec;
  logic          dly_extra_clk;
  logic          qdr_reset;

  logic [31:0]   pat [MAX_LINES*5];
  int            pattern_lines = 0;
  int            pulse_i [36] = '{default: 0};
  int            pulse_o [37] = '{default: 0};
  int            exp_i [36] = '{default: 0};
  int            exp_o [37] = '{default: 0};
  dly_in_mask_t  model_i = '0;
  dly_out_mask_t model_o = '0;
  logic          model_inc_dec = 1'b0;

  tb_clkgen #(.RESET_CYCLES(RESET_CYCLES)) clkgen0 (
    .OPB_Clk (OPB_Clk),
    .dly_clk (dly_clk),
    .qdr_clk (qdr_clk),
    .rst_n   (rst_n)
  );

  qdr_cfg_top #(.BASE_ADDR(BASE), .HIGH_ADDR(HIGH)) dut0 (.*);

  bind qdr_dly_xfer qdr_cfg_chk chk0 (
    .dly_clk  (dly_clk),
    .rst_n    (rst_n),
    .xfer_req (xfer_req),
    .xfer_ack (xfer_ack)
  );

  always @(posedge dly_clk) begin
    for (int k = 0; k < 36; k++) begin
      if (dly_en_i[k]) pulse_i[k]++;
    end
    for (int k = 0; k < 37; k++) begin
      if (dly_en_o[k]) pulse_o[k]++;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0t %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic bus_access(input logic rnw, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output logic acked,
                            output logic [31:0] rdata, output int latency);
    logic in_win;
    in_win  = (addr >= BASE) && (addr < HIGH);
    acked   = 1'b0;
    latency = -1;
    @(posedge OPB_Clk);
    opb_abus   <= addr;
    opb_dbus   <= data;
    opb_be     <= be;
    opb_rnw    <= rnw;
    opb_select <= 1'b1;
    while (!acked && (in_win || latency < MISS_WAIT)) begin  // stalled writes end by watchdog
      @(negedge OPB_Clk);
      latency++;
      acked = sl_xfer_ack;
      if (!acked || !rnw) compare("sl_dbus", sl_dbus, '0);
    end
    rdata = sl_dbus;
    @(posedge OPB_Clk);
    opb_select <= 1'b0;
    @(negedge OPB_Clk);
    compare("sl_xfer_ack", sl_xfer_ack, 1'b0);
  endtask

  // a tap pulses only when its enable goes from 0 to 1
  task automatic apply_write(input reg_idx_t idx, input logic [31:0] data);
    dly_in_mask_t  new_i;
    dly_out_mask_t new_o;
    new_i = model_i;
    new_o = model_o;
    case (idx)
      REG_DLY_EN_0: new_i[31:0] = data;
      REG_DLY_EN_1: begin
        new_i[35:32] = data[3:0];
        new_o[36:32] = data[8:4];
      end
      REG_DLY_EN_2: new_o[31:0] = data;
      default: model_inc_dec = data[0];
    endcase
    for (int k = 0; k < 36; k++) begin
      if (new_i[k] && !model_i[k]) exp_i[k]++;
    end
    for (int k = 0; k < 37; k++) begin
      if (new_o[k] && !model_o[k]) exp_o[k]++;
    end
    model_i = new_i;
    model_o = new_o;
  endtask

  task automatic check_pulses();
    repeat (SETTLE) @(negedge dly_clk);
    for (int k = 0; k < 36; k++) begin
      compare($sformatf("pulse count dly_en_i[%0d]", k), pulse_i[k], exp_i[k]);
    end
    for (int k = 0; k < 37; k++) begin
      compare($sformatf("pulse count dly_en_o[%0d]", k), pulse_o[k], exp_o[k]);
    end
    compare("dly_inc_dec", dly_inc_dec, model_inc_dec);
  endtask

  task automatic check_qdr_reset(input logic want_pulse);
    logic seen;
    seen = 1'b0;
    repeat (10) begin
      @(negedge qdr_clk);
      if (qdr_reset) seen = 1'b1;
    end
    compare("qdr_reset pulse", seen, want_pulse);
    repeat (20) @(negedge qdr_clk);
    compare("qdr_reset", qdr_reset, 1'b0);
  endtask

  initial begin : watchdog
    wait (rst_n === 1'b1);
    repeat (pattern_lines * LINE_BUDGET + 20) @(posedge OPB_Clk);
    abort_run("the pattern run did not finish in the time allowed for it");
  end

  initial begin : main
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    logic [3:0]  be;
    logic [31:0] offset;
    logic [31:0] rdata;
    logic        acked;
    int          latency;
    reg_idx_t    idx;

    opb_abus     = '0;
    opb_be       = '0;
    opb_dbus     = '0;
    opb_rnw      = 1'b0;
    opb_select   = 1'b0;
    cal_fail     = 1'b1;
    phy_rdy      = 1'b1;
    dly_cntrs_lo = 32'h3c5a_0f96;
    $readmemh("verif/qdr_cfg_patterns.txt", pat);
    while (pattern_lines < MAX_LINES && pat[pattern_lines*5] != 32'd3) pattern_lines++;
    if (pattern_lines == 0 || pattern_lines == MAX_LINES) begin
      abort_run("the pattern file could not be read or has no end line");
    end

    wait (rst_n === 1'b1);
    repeat (2) @(posedge OPB_Clk);
    @(negedge OPB_Clk);
    compare("sl_xfer_ack", sl_xfer_ack, 1'b0);
    compare("sl_dbus", sl_dbus, '0);
    compare("dly_en_i", dly_en_i, '0);
    compare("dly_en_o", dly_en_o, '0);
    compare("dly_inc_dec", dly_inc_dec, 1'b0);
    compare("dly_extra_clk", dly_extra_clk, 1'b0);
    compare("qdr_reset", qdr_reset, 1'b0);

    for (int i = 0; i < pattern_lines; i++) begin
      op     = pat[i*5];
      addr   = pat[i*5+1];
      data   = pat[i*5+2];
      expv   = pat[i*5+3];
      be     = pat[i*5+4][3:0];
      offset = addr - BASE;
      idx    = offset[5:2];
      if (op == 0) begin
        check_pulses();
      end else begin
        bus_access(op == 1, addr, data, be, acked, rdata, latency);
        if (!((addr >= BASE) && (addr < HIGH))) begin
          compare($sformatf("sl_xfer_ack for %h", addr), acked, 1'b0);
        end else if (op == 1) begin
          compare("read latency", latency, 1);
          compare($sformatf("sl_dbus at %h", addr), rdata, expv);
        end else if (idx inside {[REG_DLY_EN_0:REG_DLY_INC_DEC]}) begin
          apply_write(idx, data);
        end else begin
          compare("write latency", latency, 1);
          if (idx == REG_RESET) check_qdr_reset(be[0] && data[0]);
          if (idx == REG_EXTRA_CLK) begin
            repeat (5) @(negedge qdr_clk);
            compare("dly_extra_clk", dly_extra_clk, data[0]);
          end
        end
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verif/qdr_cfg_chk.sv */
`timescale 1ns/1ps

module qdr_cfg_chk (
  input logic dly_clk,
  input logic rst_n,
  input logic xfer_req,
  input logic xfer_ack
);

  // req may only drop once the capture side has answered
  req_waits_for_ack: assert property (@(posedge dly_clk) disable iff (!rst_n)
    $fell(xfer_req) |-> xfer_ack)
    else $error("xfer_req fell while xfer_ack was still low");

  ack_needs_req: assert property (@(posedge dly_clk) disable iff (!rst_n)
    $rose(xfer_ack) |-> xfer_req)
    else $error("xfer_ack rose while xfer_req was low");

  // ack is released only after req has gone away
  ack_held_with_req: assert property (@(posedge dly_clk) disable iff (!rst_n)
    $fell(xfer_ack) |-> !xfer_req)
    else $error("xfer_ack fell while xfer_req was still high");

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int OPB_PERIOD   = 20,
  parameter int DLY_PERIOD   = 14,
  parameter int QDR_PERIOD   = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic OPB_Clk,
  output logic dly_clk,
  output logic qdr_clk,
  output logic rst_n
);

  initial begin
    OPB_Clk = 1'b0;
    forever #(OPB_PERIOD / 2) OPB_Clk = ~OPB_Clk;
  end

  initial begin
    dly_clk = 1'b0;
    forever #(DLY_PERIOD / 2) dly_clk = ~dly_clk;  // unrelated to OPB_Clk on purpose
  end

  initial begin
    qdr_clk = 1'b0;
    forever #(QDR_PERIOD / 2) qdr_clk = ~qdr_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge OPB_Clk);
    rst_n <= 1'b1;  // the other domains see this OPB edge release asynchronously
  end

endmodule

/* source/qdr_cfg_top.sv */
`timescale 1ns/1ps

module qdr_cfg_top
  import qdr_cfg_pkg::*;
#(
  parameter opb_word_t BASE_ADDR = 32'h0000_1000,
  parameter opb_word_t HIGH_ADDR = 32'h0000_1040
) (
  input  logic          OPB_Clk,
  input  logic          dly_clk,
  input  logic          qdr_clk,
  input  logic          rst_n,
  input  opb_word_t     opb_abus,
  input  logic [0:3]    opb_be,
  input  opb_word_t     opb_dbus,
  input  logic          opb_rnw,
  input  logic          opb_select,
  output logic          sl_xfer_ack,
  output opb_word_t     sl_dbus,
  input  logic          cal_fail,
  input  logic          phy_rdy,
  input  opb_word_t     dly_cntrs_lo,
  output dly_in_mask_t  dly_en_i,
  output dly_out_mask_t dly_en_o,
  output logic          dly_inc_dec,
  output logic          dly_extra_clk,
  output logic          qdr_reset
);

  logic          xfer_req;
  logic          xfer_ack;
  dly_in_mask_t  xfer_en_i;
  dly_out_mask_t xfer_en_o;
  logic          xfer_inc_dec;
  logic          reset_req;
  logic          extra_clk_sel;

  qdr_cfg_ctrl #(
    .BASE_ADDR (BASE_ADDR),
    .HIGH_ADDR (HIGH_ADDR)
  ) u_ctrl (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .opb_abus      (opb_abus),
    .opb_be        (opb_be),
    .opb_dbus      (opb_dbus),
    .opb_rnw       (opb_rnw),
    .opb_select    (opb_select),
    .cal_fail      (cal_fail),
    .phy_rdy       (phy_rdy),
    .dly_cntrs_lo  (dly_cntrs_lo),
    .xfer_ack      (xfer_ack),
    .sl_xfer_ack   (sl_xfer_ack),
    .sl_dbus       (sl_dbus),
    .xfer_req      (xfer_req),
    .xfer_en_i     (xfer_en_i),
    .xfer_en_o     (xfer_en_o),
    .xfer_inc_dec  (xfer_inc_dec),
    .reset_req     (reset_req),
    .extra_clk_sel (extra_clk_sel)
  );

  qdr_dly_xfer u_dly_xfer (
    .dly_clk      (dly_clk),
    .rst_n        (rst_n),
    .xfer_req     (xfer_req),
    .xfer_en_i    (xfer_en_i),
    .xfer_en_o    (xfer_en_o),
    .xfer_inc_dec (xfer_inc_dec),
    .xfer_ack     (xfer_ack),
    .dly_en_i     (dly_en_i),
    .dly_en_o     (dly_en_o),
    .dly_inc_dec  (dly_inc_dec)
  );

  qdr_reset_gen u_reset_gen (
    .OPB_Clk       (OPB_Clk),
    .qdr_clk       (qdr_clk),
    .rst_n         (rst_n),
    .reset_req     (reset_req),
    .extra_clk_sel (extra_clk_sel),
    .qdr_reset     (qdr_reset),
    .dly_extra_clk (dly_extra_clk)
  );

endmodule

/* source/qdr_cfg_ctrl.sv */
`timescale 1ns/1ps

module qdr_cfg_ctrl
  import qdr_cfg_pkg::*;
#(
  parameter opb_word_t BASE_ADDR = 32'h0000_1000,
  parameter opb_word_t HIGH_ADDR = 32'h0000_1040
) (
  input  logic          OPB_Clk,
  input  logic          rst_n,
  input  opb_word_t     opb_abus,
  input  logic [0:3]    opb_be,
  input  opb_word_t     opb_dbus,
  input  logic          opb_rnw,
  input  logic          opb_select,
  input  logic          cal_fail,
  input  logic          phy_rdy,
  input  opb_word_t     dly_cntrs_lo,
  input  logic          xfer_ack,
  output logic          sl_xfer_ack,
  output opb_word_t     sl_dbus,
  output logic          xfer_req,
  output dly_in_mask_t  xfer_en_i,
  output dly_out_mask_t xfer_en_o,
  output logic          xfer_inc_dec,
  output logic          reset_req,
  output logic          extra_clk_sel
);

  localparam int CNT_W = $clog2(RESET_STRETCH + 1);

  logic [31:0]      addr_off;
  logic             win_hit;
  reg_idx_t         acc_idx;
  logic             acc_new;
  logic             dly_wr;
  logic             take;

  xfer_state_t      state;
  logic             ack_meta;
  logic             ack_sync;

  dly_in_mask_t     en_i_q;
  dly_out_mask_t    en_o_q;
  logic             inc_dec_q;
  logic             extra_q;
  logic [CNT_W-1:0] rst_cnt;

  reg_idx_t         rd_idx;
  logic             rd_q;

  assign addr_off = opb_abus - BASE_ADDR;
  assign win_hit  = opb_select && (opb_abus >= BASE_ADDR) && (opb_abus < HIGH_ADDR);
  assign acc_idx  = addr_off[5:2];          // byte to word index
  assign acc_new  = win_hit && !sl_xfer_ack; // one ack per select
  assign dly_wr   = !opb_rnw && (acc_idx inside {[REG_DLY_EN_0:REG_DLY_INC_DEC]});

  // delay writes wait until the previous bundle has been handed over
  assign take = acc_new && (!dly_wr || (state == XFER_IDLE));

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      sl_xfer_ack <= 1'b0;
      rd_q        <= 1'b0;
      rd_idx      <= '0;
    end else begin
      sl_xfer_ack <= take;
      if (take) begin
        rd_q   <= opb_rnw;
        rd_idx <= acc_idx;
      end
    end
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      en_i_q    <= '0;
      en_o_q    <= '0;
      inc_dec_q <= 1'b0;
      extra_q   <= 1'b0;
      rst_cnt   <= '0;
    end else begin
      if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      if (take && !opb_rnw) begin
        case (acc_idx)
          REG_RESET: begin
            if (opb_be[3] && opb_dbus[31]) begin
              rst_cnt <= CNT_W'(RESET_STRETCH);
            end
          end
          REG_DLY_EN_0: en_i_q[31:0] <= opb_dbus;
          REG_DLY_EN_1: begin
            en_i_q[35:32] <= opb_dbus[28:31];
            en_o_q[36:32] <= opb_dbus[23:27];
          end
          REG_DLY_EN_2: en_o_q[31:0] <= opb_dbus;
          REG_DLY_INC_DEC: inc_dec_q <= opb_dbus[31];
          REG_EXTRA_CLK: extra_q <= opb_dbus[31];
          default: ;
        endcase
      end
    end
  end

  // ack comes back from dly_clk and is synchronized here
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_meta <= 1'b0;
      ack_sync <= 1'b0;
    end else begin
      ack_meta <= xfer_ack;
      ack_sync <= ack_meta;
    end
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= XFER_IDLE;
      xfer_req <= 1'b0;
    end else begin
      case (state)
        XFER_IDLE: begin
          if (take && dly_wr) begin  // bundle is written on this same edge
            xfer_req <= 1'b1;
            state    <= XFER_REQ_HIGH;
          end
        end
        XFER_REQ_HIGH: begin
          if (ack_sync) begin
            xfer_req <= 1'b0;
            state    <= XFER_WAIT_ACK_LOW;
          end
        end
        XFER_WAIT_ACK_LOW: begin
          if (!ack_sync) begin
            state <= XFER_IDLE;
          end
        end
        default: state <= XFER_IDLE;
      endcase
    end
  end

  always_comb begin
    sl_dbus = '0;
    if (sl_xfer_ack && rd_q) begin
      case (rd_idx)
        REG_STATUS: begin
          sl_dbus[23] = cal_fail;
          sl_dbus[31] = phy_rdy;
        end
        REG_DLY_EN_0: sl_dbus = en_i_q[31:0];
        REG_DLY_EN_1: begin
          sl_dbus[28:31] = en_i_q[35:32];
          sl_dbus[23:27] = en_o_q[36:32];
        end
        REG_DLY_EN_2: sl_dbus = en_o_q[31:0];
        REG_DLY_INC_DEC: sl_dbus[31] = inc_dec_q;
        REG_DLY_CNTRS0: sl_dbus = dly_cntrs_lo;
        REG_EXTRA_CLK: sl_dbus[31] = extra_q;
        default: sl_dbus = '0;
      endcase
    end
  end

  assign xfer_en_i     = en_i_q;
  assign xfer_en_o     = en_o_q;
  assign xfer_inc_dec  = inc_dec_q;
  assign extra_clk_sel = extra_q;
  assign reset_req     = (rst_cnt != '0);  // registered once more in qdr_reset_gen

endmodule

/* source/qdr_dly_xfer.sv */
`timescale 1ns/1ps

module qdr_dly_xfer
  import qdr_cfg_pkg::*;
(
  input  logic          dly_clk,
  input  logic          rst_n,
  input  logic          xfer_req,
  input  dly_in_mask_t  xfer_en_i,
  input  dly_out_mask_t xfer_en_o,
  input  logic          xfer_inc_dec,
  output logic          xfer_ack,
  output dly_in_mask_t  dly_en_i,
  output dly_out_mask_t dly_en_o,
  output logic          dly_inc_dec
);

  logic          req_meta;
  logic          req_sync;
  logic          cap_new;

  dly_in_mask_t  cap_i;
  dly_in_mask_t  prev_i;
  dly_out_mask_t cap_o;
  dly_out_mask_t prev_o;
  logic          cap_inc_dec;

  always_ff @(posedge dly_clk or negedge rst_n) begin
    if (!rst_n) begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
    end else begin
      req_meta <= xfer_req;
      req_sync <= req_meta;
    end
  end

  // the bundle has been stable since before req rose, so a plain capture is safe
  always_ff @(posedge dly_clk or negedge rst_n) begin
    if (!rst_n) begin
      xfer_ack    <= 1'b0;
      cap_new     <= 1'b0;
      cap_i       <= '0;
      cap_o       <= '0;
      prev_i      <= '0;
      prev_o      <= '0;
      cap_inc_dec <= 1'b0;
    end else begin
      cap_new <= 1'b0;
      if (req_sync && !xfer_ack) begin
        prev_i      <= cap_i;  // keep the old masks for edge detection
        prev_o      <= cap_o;
        cap_i       <= xfer_en_i;
        cap_o       <= xfer_en_o;
        cap_inc_dec <= xfer_inc_dec;
        cap_new     <= 1'b1;
        xfer_ack    <= 1'b1;
      end else if (!req_sync && xfer_ack) begin
        xfer_ack <= 1'b0;  // last phase once req has gone low
      end
    end
  end

  // a tap gets one pulse when its enable goes from 0 to 1
  always_ff @(posedge dly_clk or negedge rst_n) begin
    if (!rst_n) begin
      dly_en_i    <= '0;
      dly_en_o    <= '0;
      dly_inc_dec <= 1'b0;
    end else begin
      dly_en_i <= cap_new ? (cap_i & ~prev_i) : '0;
      dly_en_o <= cap_new ? (cap_o & ~prev_o) : '0;
      if (cap_new) begin
        dly_inc_dec <= cap_inc_dec;  // direction changes together with the pulses
      end
    end
  end

endmodule

/* source/qdr_reset_gen.sv */
`timescale 1ns/1ps

module qdr_reset_gen (
  input  logic OPB_Clk,
  input  logic qdr_clk,
  input  logic rst_n,
  input  logic reset_req,
  input  logic extra_clk_sel,
  output logic qdr_reset,
  output logic dly_extra_clk
);

  logic req_q;
  logic rst_meta;
  logic ec_meta;

  // reset_req is decoded from a counter and gets a flop before it crosses
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= reset_req;
    end
  end

  always_ff @(posedge qdr_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_meta  <= 1'b0;
      qdr_reset <= 1'b0;
    end else begin
      rst_meta  <= req_q;
      qdr_reset <= rst_meta;
    end
  end

  // the select is static so two flops are enough
  always_ff @(posedge qdr_clk or negedge rst_n) begin
    if (!rst_n) begin
      ec_meta       <= 1'b0;
      dly_extra_clk <= 1'b0;
    end else begin
      ec_meta       <= extra_clk_sel;
      dly_extra_clk <= ec_meta;
    end
  end

endmodule

/* source/qdr_cfg_pkg.sv */
package qdr_cfg_pkg;

  // OPB words are numbered big-endian with bit 0 as the MSB
  typedef logic [0:31] opb_word_t;

  typedef logic [35:0] dly_in_mask_t;   // one enable per input tap
  typedef logic [36:0] dly_out_mask_t;  // one enable per output tap

  typedef logic [3:0] reg_idx_t;        // byte address bits 5..2

  localparam reg_idx_t REG_RESET       = 4'd0;
  localparam reg_idx_t REG_STATUS      = 4'd1;
  localparam reg_idx_t REG_DLY_EN_0    = 4'd4;  // input mask 31..0
  localparam reg_idx_t REG_DLY_EN_1    = 4'd5;  // input 35..32 and output 36..32
  localparam reg_idx_t REG_DLY_EN_2    = 4'd6;  // output mask 31..0
  localparam reg_idx_t REG_DLY_INC_DEC = 4'd7;
  localparam reg_idx_t REG_DLY_CNTRS0  = 4'd8;
  localparam reg_idx_t REG_EXTRA_CLK   = 4'd9;

  // reset request length in OPB cycles
  localparam int RESET_STRETCH = 5;

  // req side of the four-phase handshake into dly_clk
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_REQ_HIGH,
    XFER_WAIT_ACK_LOW
  } xfer_state_t;

endpackage
